// File: verilog/mem_pkg.sv
// memory stage shared definitions
`default_nettype none

package mem_pkg;

    // widths fixed by the 32-bit ISA
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SEL_W      = 4;

    // cp0 register numbers
    localparam logic [4:0] CP0_STATUS = 5'd12;
    localparam logic [4:0] CP0_CAUSE  = 5'd13;
    localparam logic [4:0] CP0_EPC    = 5'd14;

    // bit positions in the exception flag word from execute
    localparam int EXC_SYSCALL_BIT = 8;
    localparam int EXC_RI_BIT      = 9;
    localparam int EXC_TRAP_BIT    = 10;
    localparam int EXC_OV_BIT      = 11;
    localparam int EXC_ERET_BIT    = 12;

    // memory opcodes, same encoding as the decode stage
    typedef enum logic [7:0] {
        OP_NOP = 8'b0000_0000,
        OP_LB  = 8'b1110_0000,
        OP_LBU = 8'b1110_0100,
        OP_LH  = 8'b1110_0001,
        OP_LHU = 8'b1110_0101,
        OP_LW  = 8'b1110_0011,
        OP_SB  = 8'b1110_1000,
        OP_SH  = 8'b1110_1001,
        OP_SW  = 8'b1110_1011
    } mem_op_e;

    // resolved exception codes handed to writeback
    typedef enum logic [31:0] {
        EXC_NONE = 32'h0000_0000,
        EXC_INT  = 32'h0000_0001,
        EXC_SYS  = 32'h0000_0008,
        EXC_RI   = 32'h0000_000a,
        EXC_OV   = 32'h0000_000c,
        EXC_TR   = 32'h0000_000d,
        EXC_ERET = 32'h0000_000e
    } exc_code_e;

endpackage

`default_nettype wire

// File: verilog/dbus_if.sv
// data bus interface
`timescale 1ns/1ps
`default_nettype none

interface dbus_if;

    // request side
    logic [31:0] addr;
    logic [3:0]  sel;
    logic [31:0] wdata;
    logic        we;
    logic        ce;

    // response side
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        write_pending;

    modport master (output addr, sel, wdata, we, ce,
                    input  rdata, rdata_valid, write_pending);

    modport port (input  addr, sel, wdata, we, ce,
                  output rdata, rdata_valid, write_pending);

endinterface

`default_nettype wire

// File: verilog/load_align.sv
// load data alignment
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire mem_pkg::mem_op_e              op_i,
    input  wire logic [1:0]                    addr_lsb_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    rdata_i,
    output logic      [mem_pkg::WORD_W-1:0]    data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        half_ok;

    // big-endian: offset 0 is the top byte
    always_comb begin
        case (addr_lsb_i)
            2'b00:   byte_lane = rdata_i[31:24];
            2'b01:   byte_lane = rdata_i[23:16];
            2'b10:   byte_lane = rdata_i[15:8];
            default: byte_lane = rdata_i[7:0];
        endcase
    end

    assign half_lane = addr_lsb_i[1] ? rdata_i[15:0] : rdata_i[31:16];
    assign half_ok   = ~addr_lsb_i[0];

    always_comb begin
        case (op_i)
            mem_pkg::OP_LB:  data_o = {{24{byte_lane[7]}}, byte_lane};
            mem_pkg::OP_LBU: data_o = {24'd0, byte_lane};
            mem_pkg::OP_LH: begin
                data_o = half_ok ? {{16{half_lane[15]}}, half_lane} : '0;
            end
            mem_pkg::OP_LHU: begin
                data_o = half_ok ? {16'd0, half_lane} : '0;
            end
            mem_pkg::OP_LW:  data_o = rdata_i;
            default:         data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mem_access.sv
// memory access and load formatting
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  wire mem_pkg::mem_op_e              aluop_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    mem_addr_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    reg2_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    wdata_i,
    input  wire logic                          wreg_i,
    input  wire logic                          exc_taken_i,
    dbus_if.master                             bus,
    output logic      [mem_pkg::WORD_W-1:0]    wdata_o,
    output logic                               stall_o
);

    logic                         is_load;
    logic                         is_store;
    logic [mem_pkg::SEL_W-1:0]    sel;
    logic [mem_pkg::SEL_W-1:0]    byte_sel;
    logic [mem_pkg::SEL_W-1:0]    half_sel;
    logic [mem_pkg::WORD_W-1:0]   store_data;
    logic [mem_pkg::WORD_W-1:0]   load_data;
    logic                         re;

    // one lane per byte, msb lane at offset 0
    assign byte_sel = 4'b1000 >> mem_addr_i[1:0];

    always_comb begin
        case (mem_addr_i[1:0])
            2'b00:   half_sel = 4'b1100;
            2'b10:   half_sel = 4'b0011;
            default: half_sel = 4'b0000;
        endcase
    end

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        sel        = '0;
        store_data = '0;
        case (aluop_i)
            mem_pkg::OP_LB, mem_pkg::OP_LBU: begin
                is_load = 1'b1;
                sel     = byte_sel;
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU: begin
                is_load = 1'b1;
                sel     = half_sel;
            end
            mem_pkg::OP_LW: begin
                is_load = 1'b1;
                sel     = 4'b1111;
            end
            mem_pkg::OP_SB: begin
                is_store   = 1'b1;
                sel        = byte_sel;
                store_data = {4{reg2_i[7:0]}};
            end
            mem_pkg::OP_SH: begin
                is_store   = 1'b1;
                sel        = half_sel;
                store_data = {2{reg2_i[15:0]}};
            end
            mem_pkg::OP_SW: begin
                is_store   = 1'b1;
                sel        = 4'b1111;
                store_data = reg2_i;
            end
            default: begin
            end
        endcase
    end

    // bus request, cancelled by a taken exception
    assign bus.addr  = (is_load | is_store) ? mem_addr_i : '0;
    assign bus.sel   = sel;
    assign bus.wdata = store_data;
    assign bus.ce    = (is_load | is_store) & ~exc_taken_i;
    assign bus.we    = is_store & ~exc_taken_i;

    load_align u_load_align (
        .op_i       (aluop_i),
        .addr_lsb_i (mem_addr_i[1:0]),
        .rdata_i    (bus.rdata),
        .data_o     (load_data)
    );

    // load result only matters when a register is written
    assign wdata_o = (is_load & wreg_i) ? load_data : wdata_i;

    // hold the pipe until read data arrives or the write drains
    assign re      = bus.ce & ~bus.we;
    assign stall_o = (re & ~bus.rdata_valid) | (bus.we & bus.write_pending);

endmodule

`default_nettype wire

// File: verilog/exception_unit.sv
// cp0 forwarding and exception resolution
`timescale 1ns/1ps
`default_nettype none

module exception_unit (
    input  wire logic [mem_pkg::WORD_W-1:0]    inst_addr_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    excepttype_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    cp0_status_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    cp0_cause_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    cp0_epc_i,
    input  wire logic                          wb_cp0_we_i,
    input  wire logic [4:0]                    wb_cp0_addr_i,
    input  wire logic [mem_pkg::WORD_W-1:0]    wb_cp0_data_i,
    output mem_pkg::exc_code_e                 exc_code_o,
    output logic                               exc_taken_o,
    output logic      [mem_pkg::WORD_W-1:0]    epc_o
);

    logic                         wb_status;
    logic                         wb_cause;
    logic                         wb_epc;
    logic [mem_pkg::WORD_W-1:0]   status_fwd;
    logic [mem_pkg::WORD_W-1:0]   cause_fwd;
    logic                         int_pending;

    assign wb_status = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_STATUS);
    assign wb_cause  = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_CAUSE);
    assign wb_epc    = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_EPC);

    assign status_fwd = wb_status ? wb_cp0_data_i : cp0_status_i;
    assign epc_o      = wb_epc ? wb_cp0_data_i : cp0_epc_i;

    // only IP[1:0], WP and IV are software writable in cause
    always_comb begin
        cause_fwd = cp0_cause_i;
        if (wb_cause) begin
            cause_fwd[9:8]   = wb_cp0_data_i[9:8];
            cause_fwd[23:22] = wb_cp0_data_i[23:22];
        end
    end

    // masked interrupt, EXL clear and IE set
    assign int_pending = (|(cause_fwd[15:8] & status_fwd[15:8]))
                         && !status_fwd[1] && status_fwd[0];

    always_comb begin
        exc_code_o = mem_pkg::EXC_NONE;
        // a zero pc marks a bubble
        if (inst_addr_i != '0) begin
            if (int_pending) begin
                exc_code_o = mem_pkg::EXC_INT;
            end else if (excepttype_i[mem_pkg::EXC_SYSCALL_BIT]) begin
                exc_code_o = mem_pkg::EXC_SYS;
            end else if (excepttype_i[mem_pkg::EXC_RI_BIT]) begin
                exc_code_o = mem_pkg::EXC_RI;
            end else if (excepttype_i[mem_pkg::EXC_TRAP_BIT]) begin
                exc_code_o = mem_pkg::EXC_TR;
            end else if (excepttype_i[mem_pkg::EXC_OV_BIT]) begin
                exc_code_o = mem_pkg::EXC_OV;
            end else if (excepttype_i[mem_pkg::EXC_ERET_BIT]) begin
                exc_code_o = mem_pkg::EXC_ERET;
            end
        end
    end

    assign exc_taken_o = (exc_code_o != mem_pkg::EXC_NONE);

endmodule

`default_nettype wire

// File: verilog/mem_wb_reg.sv
// mem to writeback pipeline register
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  wire logic                              clk,
    input  wire logic                              reset_i,
    input  wire logic                              stall_i,
    input  wire logic [mem_pkg::REG_ADDR_W-1:0]    wd_i,
    input  wire logic                              wreg_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        wdata_i,
    input  wire mem_pkg::exc_code_e                exc_code_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        epc_i,
    output logic      [mem_pkg::REG_ADDR_W-1:0]    wb_wd_o,
    output logic                                   wb_wreg_o,
    output logic      [mem_pkg::WORD_W-1:0]        wb_wdata_o,
    output mem_pkg::exc_code_e                     wb_excepttype_o,
    output logic      [mem_pkg::WORD_W-1:0]        wb_epc_o
);

    // bubble on reset or stall
    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            wb_wd_o         <= '0;
            wb_wreg_o       <= 1'b0;
            wb_wdata_o      <= '0;
            wb_excepttype_o <= mem_pkg::EXC_NONE;
            wb_epc_o        <= '0;
        end else begin
            wb_wd_o         <= wd_i;
            wb_wreg_o       <= wreg_i;
            wb_wdata_o      <= wdata_i;
            wb_excepttype_o <= exc_code_i;
            wb_epc_o        <= epc_i;
        end
    end

    // a stalled instruction never reaches the register file
    assert property (@(posedge clk) disable iff (reset_i)
        stall_i |=> !wb_wreg_o)
        else $error("register write leaked past a stall");

endmodule

`default_nettype wire

// File: verilog/mem_stage_top.sv
// memory stage top level
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
    input  wire logic                              clk,
    input  wire logic                              reset_i,
    input  wire logic [mem_pkg::REG_ADDR_W-1:0]    wd_i,
    input  wire logic                              wreg_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        wdata_i,
    input  wire mem_pkg::mem_op_e                  aluop_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        mem_addr_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        reg2_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        excepttype_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        inst_addr_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        cp0_status_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        cp0_cause_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        cp0_epc_i,
    input  wire logic                              wb_cp0_we_i,
    input  wire logic [4:0]                        wb_cp0_addr_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        wb_cp0_data_i,
    input  wire logic [mem_pkg::WORD_W-1:0]        dbus_rdata_i,
    input  wire logic                              dbus_rdata_valid_i,
    input  wire logic                              dbus_write_pending_i,
    output logic      [mem_pkg::WORD_W-1:0]        dbus_addr_o,
    output logic      [mem_pkg::SEL_W-1:0]         dbus_sel_o,
    output logic      [mem_pkg::WORD_W-1:0]        dbus_wdata_o,
    output logic                                   dbus_we_o,
    output logic                                   dbus_re_o,
    output logic                                   stall_o,
    output logic      [mem_pkg::REG_ADDR_W-1:0]    wb_wd_o,
    output logic                                   wb_wreg_o,
    output logic      [mem_pkg::WORD_W-1:0]        wb_wdata_o,
    output mem_pkg::exc_code_e                     wb_excepttype_o,
    output logic      [mem_pkg::WORD_W-1:0]        wb_epc_o
);

    logic                         exc_taken;
    mem_pkg::exc_code_e           exc_code;
    logic [mem_pkg::WORD_W-1:0]   epc;
    logic [mem_pkg::WORD_W-1:0]   mem_wdata;

    dbus_if bus ();

    // external data bus
    assign dbus_addr_o       = bus.addr;
    assign dbus_sel_o        = bus.sel;
    assign dbus_wdata_o      = bus.wdata;
    assign dbus_we_o         = bus.we;
    assign dbus_re_o         = bus.ce & ~bus.we;
    assign bus.rdata         = dbus_rdata_i;
    assign bus.rdata_valid   = dbus_rdata_valid_i;
    assign bus.write_pending = dbus_write_pending_i;

    mem_access u_mem_access (
        .aluop_i     (aluop_i),
        .mem_addr_i  (mem_addr_i),
        .reg2_i      (reg2_i),
        .wdata_i     (wdata_i),
        .wreg_i      (wreg_i),
        .exc_taken_i (exc_taken),
        .bus         (bus.master),
        .wdata_o     (mem_wdata),
        .stall_o     (stall_o)
    );

    exception_unit u_exception_unit (
        .inst_addr_i   (inst_addr_i),
        .excepttype_i  (excepttype_i),
        .cp0_status_i  (cp0_status_i),
        .cp0_cause_i   (cp0_cause_i),
        .cp0_epc_i     (cp0_epc_i),
        .wb_cp0_we_i   (wb_cp0_we_i),
        .wb_cp0_addr_i (wb_cp0_addr_i),
        .wb_cp0_data_i (wb_cp0_data_i),
        .exc_code_o    (exc_code),
        .exc_taken_o   (exc_taken),
        .epc_o         (epc)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_o),
        .wd_i            (wd_i),
        .wreg_i          (wreg_i),
        .wdata_i         (mem_wdata),
        .exc_code_i      (exc_code),
        .epc_i           (epc),
        .wb_wd_o         (wb_wd_o),
        .wb_wreg_o       (wb_wreg_o),
        .wb_wdata_o      (wb_wdata_o),
        .wb_excepttype_o (wb_excepttype_o),
        .wb_epc_o        (wb_epc_o)
    );

    // exception cancels the access, so nothing is left to wait on
    assert property (@(posedge clk) disable iff (reset_i)
        exc_taken |-> (!bus.ce && !stall_o))
        else $error("bus access or stall survived a taken exception");

endmodule

`default_nettype wire

// File: bench/mem_stage_tb.sv
// memory stage testbench
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

    typedef struct packed {
        mem_pkg::mem_op_e   op;
        logic [31:0]        addr, reg2, wdata, excepttype, inst_addr;
        logic [31:0]        status, cause, epc, cp0_data, rdata;
        logic [4:0]         wd, cp0_addr;
        logic               wreg, cp0_we, rvalid, wpend;
        // expected responses
        logic [31:0]        x_addr, x_bwdata, x_result, x_epc;
        logic [3:0]         x_sel;
        logic               x_we, x_re, x_stall;
        mem_pkg::exc_code_e x_exc;
    } entry_t;

    logic               clk = 1'b0;
    logic               reset_i, wreg_i, wb_cp0_we_i;
    logic               dbus_rdata_valid_i, dbus_write_pending_i;
    logic [4:0]         wd_i, wb_cp0_addr_i;
    logic [31:0]        wdata_i, mem_addr_i, reg2_i, excepttype_i, inst_addr_i;
    logic [31:0]        cp0_status_i, cp0_cause_i, cp0_epc_i, wb_cp0_data_i, dbus_rdata_i;
    mem_pkg::mem_op_e   aluop_i;
    logic [31:0]        dbus_addr_o, dbus_wdata_o, wb_wdata_o, wb_epc_o;
    logic [3:0]         dbus_sel_o;
    logic               dbus_we_o, dbus_re_o, stall_o, wb_wreg_o;
    logic [4:0]         wb_wd_o;
    mem_pkg::exc_code_e wb_excepttype_o;

    entry_t             table_q[$];
    entry_t             cur;
    integer             seed = 60156;
    int                 errors = 0;
    int                 checks = 0;
    logic               table_ready = 1'b0;

    mem_stage_top dut (.*);

    always #10 clk = ~clk;

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sel(string name, logic [3:0] got, logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_exc(string name, mem_pkg::exc_code_e got, mem_pkg::exc_code_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %s expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic new_entry();
        cur = '0;
        cur.op = mem_pkg::OP_NOP;
        cur.addr = 32'h1000_0040;
        cur.reg2 = $random(seed);
        cur.wdata = $random(seed);
        cur.rdata = $random(seed);
        cur.wreg = 1'b1;
        cur.wd = 5'(table_q.size() + 1);
        cur.inst_addr = 32'h0040_0000 + 32'(4 * table_q.size());
        cur.epc = 32'hbfc0_0100;
        cur.rvalid = 1'b1;
    endtask

    // work out the expected responses, then queue the entry
    task automatic push_entry();
        logic [1:0]  off;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] st;
        logic [31:0] ca;
        logic [31:0] ld_val;
        logic        ld;
        logic        sto;
        logic        irq;
        off = cur.addr[1:0];
        b = 8'(cur.rdata >> (8 * (3 - int'(off))));
        h = off[1] ? cur.rdata[15:0] : cur.rdata[31:16];
        ld = 1'b0;
        sto = 1'b0;
        ld_val = 32'd0;
        cur.x_sel = 4'b0000;
        cur.x_bwdata = 32'd0;
        case (cur.op)
            mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: begin
                cur.x_sel = 4'b0001 << (2'd3 - off);
                ld_val = (cur.op == mem_pkg::OP_LB) ? {{24{b[7]}}, b} : {24'd0, b};
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: begin
                cur.x_sel = (off == 2'd0) ? 4'b1100 : ((off == 2'd2) ? 4'b0011 : 4'b0000);
                ld_val = (cur.op == mem_pkg::OP_LH) ? {{16{h[15]}}, h} : {16'd0, h};
                if (off[0]) begin
                    ld_val = 32'd0;
                end
            end
            mem_pkg::OP_LW, mem_pkg::OP_SW: begin
                cur.x_sel = 4'b1111;
                ld_val = cur.rdata;
            end
            default: begin
            end
        endcase
        ld = cur.op inside {mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH,
                            mem_pkg::OP_LHU, mem_pkg::OP_LW};
        sto = cur.op inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW};
        if (cur.op == mem_pkg::OP_SB) cur.x_bwdata = {4{cur.reg2[7:0]}};
        if (cur.op == mem_pkg::OP_SH) cur.x_bwdata = {2{cur.reg2[15:0]}};
        if (cur.op == mem_pkg::OP_SW) cur.x_bwdata = cur.reg2;
        // cp0 values as seen after writeback forwarding
        st = (cur.cp0_we && cur.cp0_addr == mem_pkg::CP0_STATUS) ? cur.cp0_data : cur.status;
        ca = cur.cause;
        if (cur.cp0_we && cur.cp0_addr == mem_pkg::CP0_CAUSE) begin
            ca[9:8] = cur.cp0_data[9:8];
            ca[23:22] = cur.cp0_data[23:22];
        end
        cur.x_epc = (cur.cp0_we && cur.cp0_addr == mem_pkg::CP0_EPC) ? cur.cp0_data : cur.epc;
        irq = (|(ca[15:8] & st[15:8])) && !st[1] && st[0];
        cur.x_exc = mem_pkg::EXC_NONE;
        if (cur.inst_addr != 32'd0) begin
            if (irq) cur.x_exc = mem_pkg::EXC_INT;
            else if (cur.excepttype[mem_pkg::EXC_SYSCALL_BIT]) cur.x_exc = mem_pkg::EXC_SYS;
            else if (cur.excepttype[mem_pkg::EXC_RI_BIT]) cur.x_exc = mem_pkg::EXC_RI;
            else if (cur.excepttype[mem_pkg::EXC_TRAP_BIT]) cur.x_exc = mem_pkg::EXC_TR;
            else if (cur.excepttype[mem_pkg::EXC_OV_BIT]) cur.x_exc = mem_pkg::EXC_OV;
            else if (cur.excepttype[mem_pkg::EXC_ERET_BIT]) cur.x_exc = mem_pkg::EXC_ERET;
        end
        cur.x_addr = (ld || sto) ? cur.addr : 32'd0;
        cur.x_we = sto && (cur.x_exc == mem_pkg::EXC_NONE);
        cur.x_re = ld && (cur.x_exc == mem_pkg::EXC_NONE);
        cur.x_stall = (cur.x_re && !cur.rvalid) || (cur.x_we && cur.wpend);
        cur.x_result = ld ? ld_val : cur.wdata;
        table_q.push_back(cur);
    endtask

    task automatic add_access(mem_pkg::mem_op_e op, logic [1:0] off, logic [31:0] rd,
                              logic [31:0] flags);
        new_entry();
        cur.op = op;
        cur.addr[1:0] = off;
        cur.rdata = rd;
        cur.excepttype = flags;
        push_entry();
    endtask

    task automatic build_table();
        logic [31:0] rd;
        // loads on random data and on two patterns with both signs in every lane
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 4; k++) begin
                case (p)
                    0:       rd = $random(seed);
                    1:       rd = 32'h8a7f_70f1;
                    default: rd = 32'h7580_8f0e;
                endcase
                add_access(mem_pkg::OP_LB, 2'(k), rd, 32'd0);
                add_access(mem_pkg::OP_LBU, 2'(k), rd, 32'd0);
                add_access(mem_pkg::OP_LH, 2'(k), rd, 32'd0);
                add_access(mem_pkg::OP_LHU, 2'(k), rd, 32'd0);
            end
            add_access(mem_pkg::OP_LW, 2'd0, rd, 32'd0);
        end
        for (int k = 0; k < 4; k++) begin
            add_access(mem_pkg::OP_SB, 2'(k), 32'd0, 32'd0);
            add_access(mem_pkg::OP_SH, 2'(k), 32'd0, 32'd0);
        end
        add_access(mem_pkg::OP_SW, 2'd0, 32'd0, 32'd0);
        // single flags on loads, cumulative flag sets on stores
        for (int k = 8; k <= 12; k++) begin
            add_access(mem_pkg::OP_LW, 2'd0, 32'd0, 32'h1 << k);
            add_access(mem_pkg::OP_SW, 2'd0, 32'd0, 32'h1f00 & ~((32'h1 << k) - 32'h1));
        end
        // interrupt beats all flags, exl masks it, zero pc gives none
        add_access(mem_pkg::OP_LB, 2'd1, 32'd0, 32'h1f00);
        cur.status = 32'h0000_ff01;
        cur.cause = 32'h0000_0400;
        push_entry();
        cur.status = 32'h0000_ff03;
        push_entry();
        cur.inst_addr = 32'd0;
        push_entry();
        // forwarded status, writable cause bits, read-only IP2, forwarded epc
        add_access(mem_pkg::OP_SB, 2'd2, 32'd0, 32'd0);
        cur.cause = 32'h0000_0400;
        cur.cp0_we = 1'b1;
        cur.cp0_addr = mem_pkg::CP0_STATUS;
        cur.cp0_data = 32'h0000_0401;
        push_entry();
        cur.status = 32'h0000_0101;
        cur.cp0_addr = mem_pkg::CP0_CAUSE;
        cur.cp0_data = 32'h0000_0100;
        push_entry();
        cur.status = 32'h0000_0401;
        cur.cause = 32'd0;
        cur.cp0_data = 32'h0000_0400;
        push_entry();
        cur.cp0_addr = mem_pkg::CP0_EPC;
        cur.cp0_data = 32'h8000_0180;
        cur.excepttype = 32'h0000_0100;
        push_entry();
        // late read data, slow write drain, and an exception with no wait
        add_access(mem_pkg::OP_LHU, 2'd2, $random(seed), 32'd0);
        cur.rvalid = 1'b0;
        push_entry();
        push_entry();
        cur.rvalid = 1'b1;
        push_entry();
        cur.op = mem_pkg::OP_SW;
        cur.wpend = 1'b1;
        push_entry();
        cur.wpend = 1'b0;
        push_entry();
        cur.op = mem_pkg::OP_LW;
        cur.rvalid = 1'b0;
        cur.excepttype = 32'h0000_0800;
        push_entry();
    endtask

    task automatic apply(entry_t e);
        aluop_i = e.op;
        mem_addr_i = e.addr;
        reg2_i = e.reg2;
        wdata_i = e.wdata;
        wreg_i = e.wreg;
        wd_i = e.wd;
        excepttype_i = e.excepttype;
        inst_addr_i = e.inst_addr;
        cp0_status_i = e.status;
        cp0_cause_i = e.cause;
        cp0_epc_i = e.epc;
        wb_cp0_we_i = e.cp0_we;
        wb_cp0_addr_i = e.cp0_addr;
        wb_cp0_data_i = e.cp0_data;
        dbus_rdata_i = e.rdata;
        dbus_rdata_valid_i = e.rvalid;
        dbus_write_pending_i = e.wpend;
    endtask

    task automatic check_bus(entry_t e);
        check_word("dbus_addr_o", dbus_addr_o, e.x_addr);
        check_sel("dbus_sel_o", dbus_sel_o, e.x_sel);
        check_word("dbus_wdata_o", dbus_wdata_o, e.x_bwdata);
        check_bit("dbus_we_o", dbus_we_o, e.x_we);
        check_bit("dbus_re_o", dbus_re_o, e.x_re);
        check_bit("stall_o", stall_o, e.x_stall);
    endtask

    // a stalled entry leaves a bubble behind
    task automatic check_wb(entry_t e);
        logic b;
        b = e.x_stall;
        check_word("wb_wd_o", {27'd0, wb_wd_o}, b ? 32'd0 : {27'd0, e.wd});
        check_bit("wb_wreg_o", wb_wreg_o, b ? 1'b0 : e.wreg);
        check_word("wb_wdata_o", wb_wdata_o, b ? 32'd0 : e.x_result);
        check_exc("wb_excepttype_o", wb_excepttype_o, b ? mem_pkg::EXC_NONE : e.x_exc);
        check_word("wb_epc_o", wb_epc_o, b ? 32'd0 : e.x_epc);
    endtask

    initial begin
        reset_i = 1'b1;
        new_entry();
        apply(cur);
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_word("wb_wd_o", {27'd0, wb_wd_o}, 32'd0);
        check_bit("wb_wreg_o", wb_wreg_o, 1'b0);
        check_word("wb_wdata_o", wb_wdata_o, 32'd0);
        check_exc("wb_excepttype_o", wb_excepttype_o, mem_pkg::EXC_NONE);
        check_word("wb_epc_o", wb_epc_o, 32'd0);
        for (int i = 0; i < table_q.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
                check_wb(table_q[i - 1]);
            end
            apply(table_q[i]);
            #1;
            check_bus(table_q[i]);
        end
        @(negedge clk);
        check_wb(table_q[table_q.size() - 1]);
        $display("entries %0d checks %0d errors %0d", table_q.size(), checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((table_q.size() + 20) * 20);
        $display("timeout: the table did not finish within %0d cycles", table_q.size() + 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/mem_pkg.sv
verilog/dbus_if.sv
verilog/load_align.sv
verilog/mem_access.sv
verilog/exception_unit.sv
verilog/mem_wb_reg.sv
verilog/mem_stage_top.sv
bench/mem_stage_tb.sv

// File: Makefile
# memory stage simulation with Verilator
TOP := mem_stage_tb

.PHONY: help test clean

help:
	@echo "test   build the testbench with Verilator and run it"
	@echo "clean  remove the Verilator build directory"
	@echo "help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
